//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module chip_block_tb -f filelist.f
	out=$$(./obj_dir/Vchip_block_tb); echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

//--- filelist.f
source/chip_pkg.sv
source/chip_tag_client.sv
source/chip_link_rx.sv
source/chip_link_tx.sv
source/chip_core_complex.sv
source/chip_block.sv
verif/chip_block_sva.sv
verif/chip_block_tb.sv

//--- source/chip_block.sv
`timescale 1ns/1ps

module chip_block
  #(parameter int                               fifo_depth_p  = 4
   ,parameter logic [chip_pkg::id_width_gp-1:0] tag_node_id_p = 4'h3
   )
  (input  logic               ext_noc_clk_i
  ,input  logic               rst_n_i

  ,input  logic               tag_data_i
  ,input  logic               tag_en_i

  ,input  logic               fwd_link_v_i
  ,input  chip_pkg::fwd_pkt_s fwd_link_data_i
  ,output logic               fwd_link_token_o

  ,output logic               rev_link_v_o
  ,output chip_pkg::rev_pkt_s rev_link_data_o
  ,input  logic               rev_link_token_i
  );

  //////////////////////////////////////////////////////////////////////
  // Tag
  //////////////////////////////////////////////////////////////////////

  logic               tag_data_lo;
  chip_pkg::tag_cfg_s cfg_lo;

  assign tag_data_lo = tag_en_i & tag_data_i;

  chip_tag_client
    #(.tag_node_id_p (tag_node_id_p))
  u_tag
    (.ext_noc_clk_i (ext_noc_clk_i)
    ,.rst_n_i       (rst_n_i      )
    ,.tag_data_i    (tag_data_lo  )
    ,.cfg_o         (cfg_lo       )
    );

  //////////////////////////////////////////////////////////////////////
  // Forward link
  //////////////////////////////////////////////////////////////////////

  logic               head_v_lo;
  chip_pkg::fwd_pkt_s head_lo;
  logic               pop_lo;

  chip_link_rx
    #(.fifo_depth_p (fifo_depth_p))
  u_rx
    (.ext_noc_clk_i (ext_noc_clk_i   )
    ,.rst_n_i       (rst_n_i         )
    ,.link_v_i      (fwd_link_v_i    )
    ,.link_data_i   (fwd_link_data_i )
    ,.pop_i         (pop_lo          )
    ,.link_token_o  (fwd_link_token_o)
    ,.head_v_o      (head_v_lo       )
    ,.head_o        (head_lo         )
    );

  //////////////////////////////////////////////////////////////////////
  // Core complex
  //////////////////////////////////////////////////////////////////////

  logic               credit_avail_lo;
  logic               resp_v_lo;
  chip_pkg::rev_pkt_s resp_lo;

  chip_core_complex u_core
    (.ext_noc_clk_i  (ext_noc_clk_i  )
    ,.rst_n_i        (rst_n_i        )
    ,.cfg_i          (cfg_lo         )
    ,.head_v_i       (head_v_lo      )
    ,.head_i         (head_lo        )
    ,.credit_avail_i (credit_avail_lo)
    ,.pop_o          (pop_lo         )
    ,.resp_v_o       (resp_v_lo      )
    ,.resp_o         (resp_lo        )
    );

  //////////////////////////////////////////////////////////////////////
  // Reverse link
  //////////////////////////////////////////////////////////////////////

  chip_link_tx
    #(.fifo_depth_p (fifo_depth_p))
  u_tx
    (.ext_noc_clk_i  (ext_noc_clk_i   )
    ,.rst_n_i        (rst_n_i         )
    ,.send_v_i       (resp_v_lo       )
    ,.send_i         (resp_lo         )
    ,.link_token_i   (rev_link_token_i)
    ,.credit_avail_o (credit_avail_lo )
    ,.link_v_o       (rev_link_v_o    )
    ,.link_data_o    (rev_link_data_o )
    );

endmodule

//--- source/chip_core_complex.sv
`timescale 1ns/1ps

module chip_core_complex
  (input  logic               ext_noc_clk_i
  ,input  logic               rst_n_i
  ,input  chip_pkg::tag_cfg_s cfg_i
  ,input  logic               head_v_i
  ,input  chip_pkg::fwd_pkt_s head_i
  ,input  logic               credit_avail_i
  ,output logic               pop_o
  ,output logic               resp_v_o
  ,output chip_pkg::rev_pkt_s resp_o
  );

  localparam int words_lp = 2 ** chip_pkg::addr_width_gp;

  logic [chip_pkg::data_width_gp-1:0] store_q [words_lp];
  logic [chip_pkg::data_width_gp-1:0] word;
  logic [chip_pkg::data_width_gp-1:0] result;
  logic                               wr_en;

  // Needs a request, a reverse credit and the enable bit
  assign pop_o = head_v_i & credit_avail_i & cfg_i.en;

  assign word = store_q[head_i.addr];

  //////////////////////////////////////////////////////////////////////
  // Execute
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    result = word;
    wr_en  = 1'b0;
    case (head_i.op)
      chip_pkg::e_op_read:
        result = word;
      chip_pkg::e_op_write:
      begin
        result = head_i.data;
        wr_en  = 1'b1;
      end
      chip_pkg::e_op_add:
      begin
        // Wraps at 16 bits
        result = word + head_i.data;
        wr_en  = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge ext_noc_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < words_lp; i++)
        store_q[i] <= '0;
    end
    else if (pop_o && wr_en)
      store_q[head_i.addr] <= result;
  end

  //////////////////////////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////////////////////////

  assign resp_v_o = pop_o;
  assign resp_o   = '{op: head_i.op, src_id: cfg_i.src_id, data: result};

endmodule

//--- source/chip_link_rx.sv
`timescale 1ns/1ps

module chip_link_rx
  #(parameter int fifo_depth_p = 4)
  (input  logic               ext_noc_clk_i
  ,input  logic               rst_n_i
  ,input  logic               link_v_i
  ,input  chip_pkg::fwd_pkt_s link_data_i
  ,input  logic               pop_i
  ,output logic               link_token_o
  ,output logic               head_v_o
  ,output chip_pkg::fwd_pkt_s head_o
  );

  localparam int ptr_width_lp = (fifo_depth_p > 1) ? $clog2(fifo_depth_p) : 1;
  localparam int cnt_width_lp = $clog2(fifo_depth_p + 1);

  chip_pkg::fwd_pkt_s      mem_q [fifo_depth_p];
  logic [ptr_width_lp-1:0] wr_ptr_q;
  logic [ptr_width_lp-1:0] rd_ptr_q;
  logic [cnt_width_lp-1:0] count_q;
  logic                    token_q;

  // Wrap for depths that are not a power of two
  function automatic logic [ptr_width_lp-1:0] ptr_next
    (input logic [ptr_width_lp-1:0] ptr);
    if (ptr == ptr_width_lp'(fifo_depth_p - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge ext_noc_clk_i)
  begin
    if (link_v_i)
      mem_q[wr_ptr_q] <= link_data_i;
  end

  always_ff @(posedge ext_noc_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      token_q  <= 1'b0;
    end
    else
    begin
      if (link_v_i)
        wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop_i)
        rd_ptr_q <= ptr_next(rd_ptr_q);
      case ({link_v_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
      // One credit back to the sender per dequeued packet
      token_q <= pop_i;
    end
  end

  assign head_v_o     = (count_q != '0);
  assign head_o       = mem_q[rd_ptr_q];
  assign link_token_o = token_q;

endmodule

//--- source/chip_link_tx.sv
`timescale 1ns/1ps

module chip_link_tx
  #(parameter int fifo_depth_p = 4)
  (input  logic               ext_noc_clk_i
  ,input  logic               rst_n_i
  ,input  logic               send_v_i
  ,input  chip_pkg::rev_pkt_s send_i
  ,input  logic               link_token_i
  ,output logic               credit_avail_o
  ,output logic               link_v_o
  ,output chip_pkg::rev_pkt_s link_data_o
  );

  localparam int cnt_width_lp = $clog2(fifo_depth_p + 1);

  logic [cnt_width_lp-1:0] credit_q;
  logic                    v_q;
  chip_pkg::rev_pkt_s      data_q;

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge ext_noc_clk_i)
  begin
    if (send_v_i)
      data_q <= send_i;
  end

  always_ff @(posedge ext_noc_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      v_q <= 1'b0;
    else
      v_q <= send_v_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Credit counter
  //////////////////////////////////////////////////////////////////////

  // Spent when the packet leaves the block
  always_ff @(posedge ext_noc_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      credit_q <= cnt_width_lp'(fifo_depth_p);
    else
    begin
      case ({v_q, link_token_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: ;
      endcase
    end
  end

  // A packet in the output register already owns one credit
  assign credit_avail_o = (credit_q > cnt_width_lp'(v_q));

  assign link_v_o    = v_q;
  assign link_data_o = data_q;

endmodule

//--- source/chip_pkg.sv
package chip_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int addr_width_gp = 4;
  localparam int data_width_gp = 16;
  localparam int id_width_gp   = 4;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0]
  {
    e_op_read  = 2'd0,
    e_op_write = 2'd1,
    e_op_add   = 2'd2
  } op_e;

  typedef enum logic [1:0]
  {
    e_tag_idle    = 2'd0,
    e_tag_id      = 2'd1,
    e_tag_payload = 2'd2
  } tag_state_e;

  //////////////////////////////////////////////////////////////////////
  // Packets and configuration
  //////////////////////////////////////////////////////////////////////

  // Request on the forward link
  typedef struct packed
  {
    op_e                      op;
    logic [addr_width_gp-1:0] addr;
    logic [data_width_gp-1:0] data;
  } fwd_pkt_s;

  // Response on the reverse link
  typedef struct packed
  {
    op_e                      op;
    logic [id_width_gp-1:0]   src_id;
    logic [data_width_gp-1:0] data;
  } rev_pkt_s;

  // en sits at bit 0, matching the serial payload order
  typedef struct packed
  {
    logic [id_width_gp-1:0] src_id;
    logic                   en;
  } tag_cfg_s;

endpackage

//--- source/chip_tag_client.sv
`timescale 1ns/1ps

module chip_tag_client
  #(parameter logic [chip_pkg::id_width_gp-1:0] tag_node_id_p = 4'h3)
  (input  logic               ext_noc_clk_i
  ,input  logic               rst_n_i
  ,input  logic               tag_data_i
  ,output chip_pkg::tag_cfg_s cfg_o
  );

  localparam int payload_width_lp = $bits(chip_pkg::tag_cfg_s);

  chip_pkg::tag_state_e                state_q;
  logic [2:0]                          bit_cnt_q;
  logic [chip_pkg::id_width_gp-1:0]    id_q;
  logic [payload_width_lp-2:0]         payload_q;
  chip_pkg::tag_cfg_s                  cfg_q;

  // Serial fields arrive lsb first, so shift in from the top
  always_ff @(posedge ext_noc_clk_i)
  begin
    if (state_q == chip_pkg::e_tag_id)
      id_q <= {tag_data_i, id_q[chip_pkg::id_width_gp-1:1]};
    if (state_q == chip_pkg::e_tag_payload)
      payload_q <= {tag_data_i, payload_q[payload_width_lp-2:1]};
  end

  always_ff @(posedge ext_noc_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q   <= chip_pkg::e_tag_idle;
      bit_cnt_q <= '0;
      cfg_q     <= '0;
    end
    else
    begin
      case (state_q)
        chip_pkg::e_tag_idle:
        begin
          // Start bit
          if (tag_data_i)
          begin
            state_q   <= chip_pkg::e_tag_id;
            bit_cnt_q <= '0;
          end
        end
        chip_pkg::e_tag_id:
        begin
          if (bit_cnt_q == 3'(chip_pkg::id_width_gp - 1))
          begin
            state_q   <= chip_pkg::e_tag_payload;
            bit_cnt_q <= '0;
          end
          else
            bit_cnt_q <= bit_cnt_q + 1'b1;
        end
        chip_pkg::e_tag_payload:
        begin
          if (bit_cnt_q == 3'(payload_width_lp - 1))
          begin
            state_q <= chip_pkg::e_tag_idle;
            // Frames for other nodes pass by untouched
            if (id_q == tag_node_id_p)
              cfg_q <= chip_pkg::tag_cfg_s'({tag_data_i, payload_q});
          end
          else
            bit_cnt_q <= bit_cnt_q + 1'b1;
        end
        default:
          state_q <= chip_pkg::e_tag_idle;
      endcase
    end
  end

  assign cfg_o = cfg_q;

endmodule

//--- verif/chip_block_sva.sv
`timescale 1ns/1ps

module chip_block_sva
  (input logic clk_i
  ,input logic rst_n_i
  ,input logic link_v_i
  ,input logic blocked_i
  ,input logic release_i
  ,input logic none_held_i
  );

  // No packet without room on the far side
  a_no_send_blocked: assert property
    (@(posedge clk_i) disable iff (!rst_n_i) !(link_v_i && blocked_i))
    else $error("link valid while blocked");

  // Only something that is held can be given back
  a_release_held: assert property
    (@(posedge clk_i) disable iff (!rst_n_i) release_i |-> !none_held_i)
    else $error("release with nothing held");

endmodule

bind chip_link_tx chip_block_sva u_tx_sva
  (.clk_i       (ext_noc_clk_i)
  ,.rst_n_i     (rst_n_i      )
  ,.link_v_i    (link_v_o     )
  ,.blocked_i   (credit_q == '0)
  ,.release_i   (link_token_i )
  ,.none_held_i (credit_q == cnt_width_lp'(fifo_depth_p))
  );

bind chip_link_rx chip_block_sva u_rx_sva
  (.clk_i       (ext_noc_clk_i)
  ,.rst_n_i     (rst_n_i      )
  ,.link_v_i    (link_v_i     )
  ,.blocked_i   (count_q == cnt_width_lp'(fifo_depth_p))
  ,.release_i   (pop_i        )
  ,.none_held_i (count_q == '0)
  );

//--- verif/chip_block_tb.sv
`timescale 1ns/1ps

module chip_block_tb;

  localparam int                               fifo_depth_lp  = 4;
  localparam logic [chip_pkg::id_width_gp-1:0] tag_node_id_lp = 4'h3;
  // All tests take a few hundred cycles
  localparam int                               max_cycles_lp  = 4000;

  logic               ext_noc_clk_i;
  logic               rst_n_i;
  logic               tag_data_i;
  logic               tag_en_i;
  logic               fwd_link_v_i;
  chip_pkg::fwd_pkt_s fwd_link_data_i;
  logic               fwd_link_token_o;
  logic               rev_link_v_o;
  chip_pkg::rev_pkt_s rev_link_data_o;
  logic               rev_link_token_i;

  logic [chip_pkg::data_width_gp-1:0] ref_mem [2**chip_pkg::addr_width_gp];
  chip_pkg::rev_pkt_s                 exp_q [$];
  chip_pkg::fwd_pkt_s                 held_q [$];
  logic [chip_pkg::id_width_gp-1:0]   cur_src;
  logic                               ret_en;
  integer                             seed;
  int                                 errors;
  int                                 cycles;
  int                                 sent_cnt;
  int                                 fwd_tok_cnt;
  int                                 rev_cnt;
  int                                 owed;

  chip_block
    #(.fifo_depth_p (fifo_depth_lp), .tag_node_id_p (tag_node_id_lp))
  u_dut
    (.ext_noc_clk_i    (ext_noc_clk_i   )
    ,.rst_n_i          (rst_n_i         )
    ,.tag_data_i       (tag_data_i      )
    ,.tag_en_i         (tag_en_i        )
    ,.fwd_link_v_i     (fwd_link_v_i    )
    ,.fwd_link_data_i  (fwd_link_data_i )
    ,.fwd_link_token_o (fwd_link_token_o)
    ,.rev_link_v_o     (rev_link_v_o    )
    ,.rev_link_data_o  (rev_link_data_o )
    ,.rev_link_token_i (rev_link_token_i)
    );

  initial ext_noc_clk_i = 1'b0;
  always #50 ext_noc_clk_i = ~ext_noc_clk_i;

  always @(posedge ext_noc_clk_i)
  begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles_lp)
    begin
      $display("Timeout at cycle %0d with %0d responses missing", cycles, exp_q.size());
      $display("Test failures found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Link peer
  ////////////////////////////////////////////////////////////////////////

  always @(negedge ext_noc_clk_i)
  begin
    if (rst_n_i && fwd_link_token_o)
      fwd_tok_cnt++;
    if (rst_n_i && rev_link_v_o)
    begin
      rev_cnt++;
      owed++;
      if (exp_q.size() == 0)
      begin
        $display("Reverse packet at %0t with no request outstanding", $time);
        errors++;
      end
      else
        check_rev("rev_link_data_o", exp_q.pop_front(), rev_link_data_o);
    end
  end

  // One reverse token per received response, held back while ret_en is low
  always @(posedge ext_noc_clk_i)
  begin
    if (ret_en && owed > 0)
    begin
      rev_link_token_i <= 1'b1;
      owed--;
    end
    else
      rev_link_token_i <= 1'b0;
  end

  task automatic check_rev(input string name, input chip_pkg::rev_pkt_s exp,
                           input chip_pkg::rev_pkt_s act);
    if (act !== exp)
    begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_cfg(input string name, input chip_pkg::tag_cfg_s exp,
                           input chip_pkg::tag_cfg_s act);
    if (act !== exp)
    begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
    begin
      $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  // Reference store update, in request order
  task automatic queue_expected(input chip_pkg::fwd_pkt_s req,
                                input logic [chip_pkg::id_width_gp-1:0] src);
    chip_pkg::rev_pkt_s resp;
    if (req.op == chip_pkg::e_op_write)
      ref_mem[req.addr] = req.data;
    else if (req.op == chip_pkg::e_op_add)
      ref_mem[req.addr] = ref_mem[req.addr] + req.data;
    resp.op     = req.op;
    resp.src_id = src;
    resp.data   = ref_mem[req.addr];
    exp_q.push_back(resp);
  endtask

  function automatic chip_pkg::fwd_pkt_s rand_req();
    logic [31:0]        r;
    chip_pkg::fwd_pkt_s req;
    r        = $random(seed);
    req.op   = chip_pkg::op_e'(r[1:0] % 2'd3);
    req.addr = r[5:2];
    req.data = r[31:16];
    return req;
  endfunction

  task automatic send_req(input chip_pkg::fwd_pkt_s req);
    while (fifo_depth_lp + fwd_tok_cnt - sent_cnt <= 0)
      @(negedge ext_noc_clk_i);
    @(posedge ext_noc_clk_i);
    fwd_link_v_i    <= 1'b1;
    fwd_link_data_i <= req;
    sent_cnt++;
    @(posedge ext_noc_clk_i);
    fwd_link_v_i <= 1'b0;
  endtask

  task automatic send_frame(input logic [3:0] id, input chip_pkg::tag_cfg_s cfg);
    logic [9:0] bits;
    bits = {cfg, id, 1'b1};
    for (int i = 0; i < 10; i++)
    begin
      @(posedge ext_noc_clk_i);
      tag_en_i   <= 1'b1;
      tag_data_i <= bits[i];
    end
    // Data stays high but gated off, which must not start a frame
    @(posedge ext_noc_clk_i);
    tag_en_i   <= 1'b0;
    tag_data_i <= 1'b1;
    repeat (3) @(posedge ext_noc_clk_i);
    @(negedge ext_noc_clk_i);
  endtask

  task automatic wait_idle();
    while (rev_cnt < sent_cnt || owed > 0)
      @(negedge ext_noc_clk_i);
    repeat (3) @(posedge ext_noc_clk_i);
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////

  task automatic test_disabled();
    chip_pkg::fwd_pkt_s req;
    for (int i = 0; i < 3; i++)
    begin
      req      = rand_req();
      req.op   = chip_pkg::e_op_write;
      req.addr = 4'(i);
      held_q.push_back(req);
      send_req(req);
    end
    repeat (20) @(posedge ext_noc_clk_i);
    @(negedge ext_noc_clk_i);
    check_count("rev_link_v_o count", 0, rev_cnt);
    check_count("fwd_link_token_o count", 0, fwd_tok_cnt);
  endtask

  task automatic test_tag_config();
    chip_pkg::tag_cfg_s cfg;
    cfg.en     = 1'b1;
    cfg.src_id = 4'ha;
    send_frame(4'h5, cfg);
    check_cfg("u_tag.cfg_o", '0, u_dut.u_tag.cfg_o);
    foreach (held_q[i])
      queue_expected(held_q[i], cfg.src_id);
    send_frame(tag_node_id_lp, cfg);
    check_cfg("u_tag.cfg_o", cfg, u_dut.u_tag.cfg_o);
    cur_src = cfg.src_id;
    wait_idle();
    check_count("held responses", 3, rev_cnt);
  endtask

  task automatic test_ops();
    chip_pkg::fwd_pkt_s req;
    int                 rev0;
    rev0 = rev_cnt;
    for (int i = 0; i < 24; i++)
    begin
      req = rand_req();
      queue_expected(req, cur_src);
      send_req(req);
    end
    wait_idle();
    check_count("responses to ops", 24, rev_cnt - rev0);
  endtask

  task automatic test_latency();
    chip_pkg::fwd_pkt_s req;
    int                 lat;
    req = rand_req();
    queue_expected(req, cur_src);
    send_req(req);
    lat = 1;
    @(negedge ext_noc_clk_i);
    while (!rev_link_v_o && lat < 10)
    begin
      @(posedge ext_noc_clk_i);
      lat++;
      @(negedge ext_noc_clk_i);
    end
    check_count("fwd to rev latency", 2, lat);
    wait_idle();
  endtask

  task automatic test_backpressure();
    chip_pkg::fwd_pkt_s req;
    int                 rev0;
    int                 tok0;
    @(negedge ext_noc_clk_i);
    ret_en = 1'b0;
    rev0   = rev_cnt;
    tok0   = fwd_tok_cnt;
    for (int i = 0; i < 2 * fifo_depth_lp; i++)
    begin
      req = rand_req();
      queue_expected(req, cur_src);
      send_req(req);
    end
    repeat (20) @(posedge ext_noc_clk_i);
    @(negedge ext_noc_clk_i);
    check_count("responses while stalled", fifo_depth_lp, rev_cnt - rev0);
    check_count("fwd tokens while stalled", fifo_depth_lp, fwd_tok_cnt - tok0);
    ret_en = 1'b1;
    wait_idle();
    check_count("responses after release", 2 * fifo_depth_lp, rev_cnt - rev0);
    check_count("fwd tokens in total", sent_cnt, fwd_tok_cnt);
  endtask

  initial
  begin
    seed             = 32'h8929c839;
    rst_n_i          = 1'b0;
    tag_data_i       = 1'b1;
    tag_en_i         = 1'b0;
    fwd_link_v_i     = 1'b0;
    fwd_link_data_i  = '0;
    rev_link_token_i = 1'b0;
    ret_en           = 1'b1;
    cur_src          = '0;
    foreach (ref_mem[i])
      ref_mem[i] = '0;
    repeat (8) @(posedge ext_noc_clk_i);
    rst_n_i <= 1'b1;
    @(posedge ext_noc_clk_i);
    test_disabled();
    test_tag_config();
    test_ops();
    test_latency();
    test_backpressure();
    $display("Run finished with %0d errors", errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule
